// File: rtl/stream_pkg.sv
`default_nettype none

package stream_pkg;

    // ======================================================================
    // field widths
    // ======================================================================
    localparam int word_w = 16;
    localparam int op_w   = 2;
    localparam int len_w  = 6;
    localparam int key_w  = 8;
    localparam int kind_w = 2;

    // tagged fifo entry is {data, op, key, last}.
    localparam int entry_w = word_w + op_w + key_w + 1;

    // ======================================================================
    // codes
    // ======================================================================
    localparam logic [op_w-1:0] op_pass    = 2'd0;
    localparam logic [op_w-1:0] op_invert  = 2'd1;
    localparam logic [op_w-1:0] op_add_key = 2'd2;
    localparam logic [op_w-1:0] op_swap    = 2'd3; // byte swap.

    localparam logic [kind_w-1:0] kind_payload  = 2'd0;
    localparam logic [kind_w-1:0] kind_checksum = 2'd1;
    localparam logic [kind_w-1:0] kind_trailer  = 2'd2;

    // one input word, read as a header or as plain payload.
    typedef union packed {
        struct packed {
            logic [op_w-1:0]  op;
            logic [len_w-1:0] len;  // payload words that follow.
            logic [key_w-1:0] key;
        } hdr;
        logic [word_w-1:0] data;
    } frame_word_u;

endpackage

`default_nettype wire

// File: rtl/frame_parser.sv
`timescale 1ns/1ps
`default_nettype none

module frame_parser (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          in_valid,
    input  stream_pkg::frame_word_u       in_word,
    output logic                          push,
    output logic [stream_pkg::entry_w-1:0] entry
);

    import stream_pkg::*;

    logic             expect_hdr;   // next strobe is a header.
    logic [len_w-1:0] remaining;    // payload words still to come.
    logic [op_w-1:0]  cur_op;
    logic [key_w-1:0] cur_key;

    logic hdr_strobe;
    logic pay_strobe;
    logic last_word;

    assign hdr_strobe = in_valid && expect_hdr;
    assign pay_strobe = in_valid && !expect_hdr;
    assign last_word  = (remaining == len_w'(1));

    // ======================================================================
    // frame tracking
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            expect_hdr <= 1'b1;
            remaining  <= '0;
            push       <= 1'b0;
        end else begin
            push <= pay_strobe;
            if (hdr_strobe) begin
                // a zero-length header is dropped and we keep waiting.
                if (in_word.hdr.len != '0) begin
                    expect_hdr <= 1'b0;
                    remaining  <= in_word.hdr.len;
                end
            end else if (pay_strobe) begin
                remaining <= remaining - 1'b1;
                if (last_word) begin
                    expect_hdr <= 1'b1;
                end
            end
        end
    end

    // header fields held for the whole frame.
    always_ff @(posedge clk) begin
        if (hdr_strobe) begin
            cur_op  <= in_word.hdr.op;
            cur_key <= in_word.hdr.key;
        end
    end

    // ======================================================================
    // tagged entry
    // ======================================================================
    always_ff @(posedge clk) begin
        if (pay_strobe) begin
            entry <= {in_word.data, cur_op, cur_key, last_word};
        end
    end

endmodule

`default_nettype wire

// File: rtl/sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter int data_width  = 8,
    parameter int fifo_depth  = 8,
    parameter int afull_level = 6
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wr_en,
    input  logic [data_width-1:0] wr_data,
    input  logic                  rd_en,
    output logic [data_width-1:0] rd_data,
    output logic                  empty,
    output logic                  almost_full,
    output logic                  overflow
);

    localparam int addr_w  = $clog2(fifo_depth);
    localparam int count_w = $clog2(fifo_depth + 1);

    localparam logic [addr_w-1:0]  last_addr = addr_w'(fifo_depth - 1);
    localparam logic [count_w-1:0] depth_cnt = count_w'(fifo_depth);
    localparam logic [count_w-1:0] afull_cnt = count_w'(afull_level);

    logic [data_width-1:0] mem [fifo_depth];
    logic [addr_w-1:0]     wr_ptr;
    logic [addr_w-1:0]     rd_ptr;
    logic [count_w-1:0]    count;

    logic full;
    logic rd_ok;
    logic wr_ok;

    // ======================================================================
    // status
    // ======================================================================
    assign full        = (count == depth_cnt);
    assign empty       = (count == '0);
    assign almost_full = (count >= afull_cnt);

    assign rd_ok = rd_en && !empty;
    // a pop in the same cycle frees the slot for a write into a full fifo.
    assign wr_ok = wr_en && (!full || rd_ok);

    // ======================================================================
    // pointers and count
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= (wr_ptr == last_addr) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= (rd_ptr == last_addr) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // one pulse per rejected write.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            overflow <= 1'b0;
        end else begin
            overflow <= wr_en && !wr_ok;
        end
    end

    // ======================================================================
    // storage
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < fifo_depth; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_ok) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // show-ahead read of the head word.
    assign rd_data = mem[rd_ptr];

endmodule

`default_nettype wire

// File: rtl/payload_transform.sv
`timescale 1ns/1ps
`default_nettype none

module payload_transform (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           empty,
    input  logic [stream_pkg::entry_w-1:0] head,
    output logic                           pop,
    output logic                           out_valid,
    output logic [stream_pkg::word_w-1:0]  out_word,
    output logic [stream_pkg::kind_w-1:0]  out_kind
);

    import stream_pkg::*;

    localparam logic [1:0] st_payload  = 2'd0;
    localparam logic [1:0] st_checksum = 2'd1;
    localparam logic [1:0] st_trailer  = 2'd2;

    logic [1:0] state;

    // head entry fields.
    logic [word_w-1:0] h_data;
    logic [op_w-1:0]   h_op;
    logic [key_w-1:0]  h_key;
    logic              h_last;

    logic [word_w-1:0] xform;
    logic [word_w-1:0] sum;        // running sum mod 2^16.
    logic [len_w-1:0]  pay_cnt;
    logic [op_w-1:0]   frame_op;   // kept for the trailer.

    assign {h_data, h_op, h_key, h_last} = head;

    assign pop = (state == st_payload) && !empty;

    // ======================================================================
    // word operation
    // ======================================================================
    always_comb begin
        case (h_op)
            op_pass:    xform = h_data;
            op_invert:  xform = ~h_data;
            op_add_key: xform = h_data + {{(word_w - key_w){1'b0}}, h_key};
            default:    xform = {h_data[7:0], h_data[15:8]};   // op_swap.
        endcase
    end

    // ======================================================================
    // control
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_payload;
            out_valid <= 1'b0;
            sum       <= '0;
            pay_cnt   <= '0;
        end else begin
            out_valid <= 1'b0;
            case (state)
                st_payload: begin
                    if (pop) begin
                        out_valid <= 1'b1;
                        sum       <= sum + xform;
                        pay_cnt   <= pay_cnt + 1'b1;
                        if (h_last) begin
                            state <= st_checksum;
                        end
                    end
                end
                st_checksum: begin
                    out_valid <= 1'b1;
                    state     <= st_trailer;
                end
                st_trailer: begin
                    out_valid <= 1'b1;
                    sum       <= '0;    // ready for the next frame.
                    pay_cnt   <= '0;
                    state     <= st_payload;
                end
                default: begin
                    state <= st_payload;
                end
            endcase
        end
    end

    // ======================================================================
    // output word
    // ======================================================================
    always_ff @(posedge clk) begin
        case (state)
            st_payload: begin
                if (pop) begin
                    out_word <= xform;
                    out_kind <= kind_payload;
                    frame_op <= h_op;
                end
            end
            st_checksum: begin
                out_word <= sum;
                out_kind <= kind_checksum;
            end
            st_trailer: begin
                out_word <= {frame_op, {(word_w - op_w - len_w){1'b0}}, pay_cnt};
                out_kind <= kind_trailer;
            end
            default: begin
                out_kind <= kind_payload;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/frame_stream_top.sv
`timescale 1ns/1ps
`default_nettype none

module frame_stream_top #(
    parameter int fifo_depth  = 8,
    parameter int afull_level = 6
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          in_valid,
    input  stream_pkg::frame_word_u       in_word,
    output logic                          out_valid,
    output logic [stream_pkg::word_w-1:0] out_word,
    output logic [stream_pkg::kind_w-1:0] out_kind,
    output logic                          almost_full,
    output logic                          overflow
);

    import stream_pkg::*;

    // parser to fifo.
    logic               push;
    logic [entry_w-1:0] entry;

    // fifo to transform.
    logic               empty;
    logic [entry_w-1:0] head;
    logic               pop;

    // ======================================================================
    // pipeline
    // ======================================================================
    frame_parser u_parser (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_word  (in_word),
        .push     (push),
        .entry    (entry)
    );

    sync_fifo #(
        .data_width  (entry_w),
        .fifo_depth  (fifo_depth),
        .afull_level (afull_level)
    ) u_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_en       (push),
        .wr_data     (entry),
        .rd_en       (pop),
        .rd_data     (head),
        .empty       (empty),
        .almost_full (almost_full),
        .overflow    (overflow)
    );

    payload_transform u_transform (
        .clk       (clk),
        .rst_n     (rst_n),
        .empty     (empty),
        .head      (head),
        .pop       (pop),
        .out_valid (out_valid),
        .out_word  (out_word),
        .out_kind  (out_kind)
    );

endmodule

`default_nettype wire

// File: bench/stream_tb.sv
`timescale 1ns/1ps
`default_nettype none

module stream_tb;

    import stream_pkg::*;

    localparam int clk_period = 4;
    localparam int n_random   = 30;
    localparam int n_after    = 4;
    localparam int n_burst    = 24;
    localparam int max_len    = 63;
    localparam int burst_len  = 12;
    localparam int max_idle   = 5;
    // worst-case input cycles over all phases.
    localparam int stim_cycles = (n_random + n_after) * (max_len + 1 + max_idle)
                               + n_burst * (burst_len + 1) + 300;

    logic              clk;
    logic              rst_n;
    logic              in_valid;
    frame_word_u       in_word;
    logic              out_valid;
    logic [word_w-1:0] out_word;
    logic [kind_w-1:0] out_kind;
    logic              almost_full;
    logic              overflow;

    logic [kind_w+word_w-1:0] expected_q[$];   // {kind, word} in output order.
    string test_name;
    logic  burst_mode;                         // loose checking while frames overflow.
    logic  saw_afull;
    int    ovf_count;

    frame_stream_top uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_word     (in_word),
        .out_valid   (out_valid),
        .out_word    (out_word),
        .out_kind    (out_kind),
        .almost_full (almost_full),
        .overflow    (overflow)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // ======================================================================
    // reference model
    // ======================================================================
    function automatic logic [word_w-1:0] apply_op(input logic [1:0] op, input logic [7:0] key,
                                                   input logic [word_w-1:0] d);
        case (op)
            op_pass:    return d;
            op_invert:  return ~d;
            op_add_key: return d + {8'h00, key};   // wraps mod 2^16.
            default:    return {d[7:0], d[15:8]};
        endcase
    endfunction

    task automatic model_frame(input logic [1:0] op, input logic [7:0] key,
                               input logic [word_w-1:0] data[$]);
        logic [word_w-1:0] y;
        logic [word_w-1:0] sum;
        sum = '0;
        if (data.size() > 0) begin
            foreach (data[i]) begin
                y = apply_op(op, key, data[i]);
                sum = sum + y;
                expected_q.push_back({kind_payload, y});
            end
            expected_q.push_back({kind_checksum, sum});
            expected_q.push_back({kind_trailer, op, 8'h00, 6'(data.size())});
        end
    endtask

    task automatic error_stop(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1, "stopping at the first error");
    endtask

    // ======================================================================
    // stimulus
    // ======================================================================
    task automatic send_frame(input logic [1:0] op, input logic [7:0] key,
                              input logic [word_w-1:0] data[$]);
        frame_word_u hdr;
        hdr.hdr.op  = op;
        hdr.hdr.len = 6'(data.size());
        hdr.hdr.key = key;
        model_frame(op, key, data);
        @(posedge clk);
        in_valid <= 1'b1;
        in_word  <= hdr;
        foreach (data[i]) begin
            @(posedge clk);
            in_word.data <= data[i];
        end
    endtask

    task automatic idle_cycles(input int n);
        if (n > 0) begin
            @(posedge clk);
            in_valid <= 1'b0;
            in_word  <= '0;
            repeat (n - 1) @(posedge clk);
        end
    endtask

    task automatic send_random_frame(input int len_hi, input int idle);
        logic [word_w-1:0] data[$];
        int len;
        len = $urandom_range(len_hi, 1);
        repeat (len) data.push_back(word_w'($urandom()));
        send_frame(2'($urandom()), 8'($urandom()), data);
        idle_cycles(idle);
    endtask

    // ends once out_valid has been low for n cycles in a row.
    task automatic wait_quiet(input int n);
        int quiet;
        quiet = 0;
        while (quiet < n) begin
            @(negedge clk);
            quiet = out_valid ? 0 : quiet + 1;
        end
        @(posedge clk);
    endtask

    // words skipped by this greedy search were dropped by the fifo.
    task automatic match_in_order(input logic [word_w-1:0] word);
        logic [kind_w+word_w-1:0] item;
        logic found;
        found = 1'b0;
        while (!found && expected_q.size() > 0) begin
            item  = expected_q.pop_front();
            found = (item[word_w+kind_w-1:word_w] == kind_payload) && (item[word_w-1:0] == word);
        end
        assert (found)
            else error_stop($sformatf("payload word %h is not in order in the expected stream",
                                      word));
    endtask

    // ======================================================================
    // output checks
    // ======================================================================
    always @(negedge clk) begin : check_outputs
        logic [kind_w+word_w-1:0] exp_item;
        if (rst_n) begin
            if (burst_mode) begin
                if (almost_full) saw_afull = 1'b1;
                if (overflow) begin
                    assert (saw_afull) else error_stop("overflow pulsed before almost_full rose");
                    ovf_count++;
                end
                // checksum and trailer differ once a word is dropped.
                if (out_valid && out_kind == kind_payload) match_in_order(out_word);
            end else begin
                assert (!overflow) else error_stop("overflow pulsed while input was paced");
                assert (!almost_full) else error_stop("almost_full rose while input was paced");
                if (out_valid) begin
                    assert (expected_q.size() > 0)
                        else error_stop("an output word came out with nothing expected");
                    exp_item = expected_q.pop_front();
                    assert ({out_kind, out_word} == exp_item)
                        else error_stop($sformatf(
                            "Fail %s: expected kind %0d word %h, actual kind %0d word %h",
                            test_name, exp_item[word_w+kind_w-1:word_w], exp_item[word_w-1:0],
                            out_kind, out_word));
                end
            end
        end
    end

    initial begin : watchdog
        repeat (stim_cycles * 4 + 1000) @(posedge clk);
        $display("watchdog expired before all phases finished");
        $display("test failed");
        $fatal(1, "timeout");
    end

    // ======================================================================
    // test sequence
    // ======================================================================
    initial begin : main_sequence
        logic [word_w-1:0] known[$];
        in_valid   = 1'b0;
        in_word    = '0;
        rst_n      = 1'b0;
        burst_mode = 1'b0;
        saw_afull  = 1'b0;
        ovf_count  = 0;
        test_name  = "reset";
        void'($urandom(96));
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        test_name = "random_paced";
        for (int f = 0; f < n_random; f++) begin
            send_random_frame(max_len, $urandom_range(max_idle, 2));
        end

        test_name = "op_known_data";
        known.push_back(16'h1234);
        known.push_back(16'h00ff);
        known.push_back(16'hff80);             // add_key wraps here.
        known.push_back(16'ha5c3);
        for (int op = 0; op < 4; op++) begin
            send_frame(2'(op), 8'h9c, known);
            idle_cycles(3);
        end

        test_name = "zero_len_header";
        known.delete();
        send_frame(op_invert, 8'h11, known);
        idle_cycles(2);
        send_random_frame(8, 2);
        wait_quiet(8);

        test_name  = "burst_overflow";
        burst_mode = 1'b1;
        for (int f = 0; f < n_burst; f++) begin
            send_random_frame(burst_len, 0);
        end
        idle_cycles(1);
        wait_quiet(8);
        assert (ovf_count > 0) else error_stop("the burst never overflowed the fifo");
        rst_n <= 1'b0;
        repeat (8) @(posedge clk);
        expected_q.delete();
        burst_mode = 1'b0;
        rst_n <= 1'b1;

        test_name = "after_reset";
        for (int f = 0; f < n_after; f++) begin
            send_random_frame(max_len, 2);
        end

        test_name = "drain_idle";
        wait_quiet(20);
        assert (expected_q.size() == 0)
            else error_stop($sformatf("%0d expected words never came out", expected_q.size()));
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
rtl/stream_pkg.sv
rtl/frame_parser.sv
rtl/sync_fifo.sv
rtl/payload_transform.sv
rtl/frame_stream_top.sv
bench/stream_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile the frame stream testbench with verilator and run it.

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -Wno-fatal --top-module stream_tb \
    -f build.f -Mdir obj_dir -o stream_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/stream_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "test passed" "$log"; then
    echo "simulation result: ok"
    exit 0
fi

echo "simulation result: pass line missing from $log"
exit 1
